// File: common/soc_bus_pkg.sv
package soc_bus_pkg;

    // bus widths
    localparam int WB_AW = 30;
    localparam int WB_DW = 32;
    localparam int WB_SW = 4;

    typedef logic [WB_AW-1:0] wb_addr_t;
    typedef logic [WB_DW-1:0] wb_data_t;
    typedef logic [WB_SW-1:0] wb_sel_t;

    // master side of a pipelined wishbone port
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
        wb_sel_t  sel;
    } wb_req_t;

    // slave side, read data shared by all masters
    typedef struct packed {
        logic     ack;
        logic     stall;
        logic     err;
        wb_data_t dat;
    } wb_rsp_t;

    // top word address bits pick an 8 MB region
    localparam int MAP_REGION_MSB = 29;
    localparam int MAP_REGION_LSB = 21;
    localparam int MAP_REGION_W   = MAP_REGION_MSB - MAP_REGION_LSB + 1;

    typedef logic [MAP_REGION_W-1:0] wb_region_t;

    localparam wb_region_t REGION_RAM = wb_region_t'(0);
    localparam wb_region_t REGION_SYS = wb_region_t'(1);

    // ram aliases every 2**RAM_AW words
    localparam int RAM_AW = 10;

    // system info register offsets, low word address bits
    localparam int REG_OFF_W = 4;

    typedef logic [REG_OFF_W-1:0] reg_off_t;

    localparam reg_off_t REG_ID       = 4'h0;
    localparam reg_off_t REG_SCRATCH  = 4'h1;
    localparam reg_off_t REG_ERR_ADDR = 4'h2;
    localparam reg_off_t REG_POWER    = 4'h3;
    localparam reg_off_t REG_IRQ      = 4'h4;

    // build identifier
    localparam wb_data_t SYS_ID = 32'h2019_1028;

endpackage

// File: rtl/wb_pri_arbiter.sv
`timescale 1ns/100ps

module wb_pri_arbiter (
    input  logic                 i_clk,
    input  logic                 reset,
    input  soc_bus_pkg::wb_req_t i_a_req,
    input  soc_bus_pkg::wb_req_t i_b_req,
    input  soc_bus_pkg::wb_rsp_t i_rsp,
    output soc_bus_pkg::wb_req_t o_req,
    output soc_bus_pkg::wb_rsp_t o_a_rsp,
    output soc_bus_pkg::wb_rsp_t o_b_rsp
);
    import soc_bus_pkg::*;

    // high while port b owns the bus
    logic    r_owner_b;
    logic    owner_cyc;
    logic    grant_b;
    wb_req_t req_mux;

    assign owner_cyc = r_owner_b ? i_b_req.cyc : i_a_req.cyc;

    // owner keeps the bus for its whole cycle
    // on an idle bus port a wins over port b
    assign grant_b = owner_cyc ? r_owner_b : (!i_a_req.cyc && i_b_req.cyc);

    always_ff @(posedge i_clk) begin
        if (reset) begin
            r_owner_b <= 1'b0;
        end else begin
            r_owner_b <= grant_b;
        end
    end

    assign req_mux = grant_b ? i_b_req : i_a_req;

    // nothing leaves the arbiter without a live cyc
    always_comb begin
        o_req     = req_mux;
        o_req.stb = req_mux.cyc && req_mux.stb;
    end

    // responses go to the owner only while the other side waits on stall
    always_comb begin
        o_a_rsp       = i_rsp;
        o_a_rsp.ack   = i_rsp.ack && !grant_b;
        o_a_rsp.err   = i_rsp.err && !grant_b;
        o_a_rsp.stall = i_rsp.stall || grant_b;

        o_b_rsp       = i_rsp;
        o_b_rsp.ack   = i_rsp.ack && grant_b;
        o_b_rsp.err   = i_rsp.err && grant_b;
        o_b_rsp.stall = i_rsp.stall || !grant_b;
    end

    // a single bus response is never delivered twice
    assert property (@(posedge i_clk) disable iff (reset)
        !(o_a_rsp.ack && o_b_rsp.ack));

    // responses only come back while the receiving master holds cyc
    assert property (@(posedge i_clk) disable iff (reset)
        (o_a_rsp.ack || o_a_rsp.err) |-> i_a_req.cyc);

    assert property (@(posedge i_clk) disable iff (reset)
        (o_b_rsp.ack || o_b_rsp.err) |-> i_b_req.cyc);

endmodule

// File: periph/periph_decode.sv
`timescale 1ns/100ps

module periph_decode (
    input  logic                  i_clk,
    input  logic                  reset,
    input  soc_bus_pkg::wb_req_t  i_req,
    input  logic                  i_ram_ack,
    input  soc_bus_pkg::wb_data_t i_ram_dat,
    input  logic                  i_sys_ack,
    input  soc_bus_pkg::wb_data_t i_sys_dat,
    output soc_bus_pkg::wb_rsp_t  o_rsp,
    output soc_bus_pkg::wb_req_t  o_ram_req,
    output soc_bus_pkg::wb_req_t  o_sys_req,
    output logic                  o_err_strobe,
    output soc_bus_pkg::wb_addr_t o_err_addr
);
    import soc_bus_pkg::*;

    wb_region_t region;
    logic       ram_sel;
    logic       sys_sel;
    logic       none_sel;
    logic       r_ack;
    logic       r_err;
    wb_data_t   r_dat;

    assign region   = i_req.adr[MAP_REGION_MSB:MAP_REGION_LSB];
    assign ram_sel  = (region == REGION_RAM);
    assign sys_sel  = (region == REGION_SYS);
    assign none_sel = !ram_sel && !sys_sel;

    // each slave only sees its own strobes
    always_comb begin
        o_ram_req     = i_req;
        o_ram_req.stb = i_req.stb && ram_sel;
        o_sys_req     = i_req;
        o_sys_req.stb = i_req.stb && sys_sel;
    end

    // unmapped strobe, address is latched on the edge that raises err
    assign o_err_strobe = i_req.stb && none_sel;
    assign o_err_addr   = i_req.adr;

    always_ff @(posedge i_clk) begin
        if (reset) begin
            r_ack <= 1'b0;
            r_err <= 1'b0;
        end else begin
            r_ack <= i_ram_ack || i_sys_ack;
            r_err <= o_err_strobe;
        end
    end

    // return data, system registers first
    always_ff @(posedge i_clk) begin
        if (i_sys_ack) begin
            r_dat <= i_sys_dat;
        end else if (i_ram_ack) begin
            r_dat <= i_ram_dat;
        end else begin
            r_dat <= '0;
        end
    end

    // no slave stalls, so the bus never does
    assign o_rsp = '{ack: r_ack, stall: 1'b0, err: r_err, dat: r_dat};

    // a slave ack and a decode error never collide
    assert property (@(posedge i_clk) disable iff (reset)
        !(o_rsp.ack && o_rsp.err));

endmodule

// File: periph/sys_info_regs.sv
`timescale 1ns/100ps

module sys_info_regs (
    input  logic                  i_clk,
    input  logic                  reset,
    input  soc_bus_pkg::wb_req_t  i_req,
    input  logic                  i_err_strobe,
    input  soc_bus_pkg::wb_addr_t i_err_addr,
    output logic                  o_ack,
    output soc_bus_pkg::wb_data_t o_dat,
    output logic                  o_irq
);
    import soc_bus_pkg::*;

    reg_off_t offset;
    wb_data_t r_scratch;
    wb_data_t r_power;
    wb_addr_t r_err_addr;

    assign offset = i_req.adr[REG_OFF_W-1:0];

    // single cycle slave, never stalls
    always_ff @(posedge i_clk) begin
        if (reset) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_req.stb;
        end
    end

    // scratch takes the full word, sel is ignored
    always_ff @(posedge i_clk) begin
        if (i_req.stb && i_req.we && offset == REG_SCRATCH) begin
            r_scratch <= i_req.dat;
        end
    end

    always_ff @(posedge i_clk) begin
        if (reset) begin
            o_irq <= 1'b0;
        end else if (i_req.stb && i_req.we && offset == REG_IRQ) begin
            o_irq <= i_req.dat[0];
        end
    end

    // last faulting word address from the decoder
    always_ff @(posedge i_clk) begin
        if (reset) begin
            r_err_addr <= '0;
        end else if (i_err_strobe) begin
            r_err_addr <= i_err_addr;
        end
    end

    // counts from power up, top bit sticks once reached
    always_ff @(posedge i_clk) begin
        if (reset) begin
            r_power <= '0;
        end else if (!r_power[WB_DW-1]) begin
            r_power <= r_power + 1'b1;
        end else begin
            r_power[WB_DW-2:0] <= r_power[WB_DW-2:0] + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req.stb) begin
            case (offset)
                REG_ID:       o_dat <= SYS_ID;
                REG_SCRATCH:  o_dat <= r_scratch;
                REG_ERR_ADDR: o_dat <= {r_err_addr, 2'b00};
                REG_POWER:    o_dat <= r_power;
                REG_IRQ:      o_dat <= {{(WB_DW-1){1'b0}}, o_irq};
                default:      o_dat <= '0;
            endcase
        end
    end

endmodule

// File: periph/wb_ram.sv
`timescale 1ns/100ps

module wb_ram (
    input  logic                  i_clk,
    input  soc_bus_pkg::wb_req_t  i_req,
    output logic                  o_ack,
    output soc_bus_pkg::wb_data_t o_dat
);
    import soc_bus_pkg::*;

    wb_data_t          mem [0:(1 << RAM_AW)-1];
    logic [RAM_AW-1:0] idx;

    // upper address bits are ignored, so the array aliases
    assign idx = i_req.adr[RAM_AW-1:0];

    // byte lane writes
    always_ff @(posedge i_clk) begin
        if (i_req.stb && i_req.we) begin
            for (int b = 0; b < WB_SW; b++) begin
                if (i_req.sel[b]) begin
                    mem[idx][8*b +: 8] <= i_req.dat[8*b +: 8];
                end
            end
        end
    end

    // read returns the word before any write on the same edge
    always_ff @(posedge i_clk) begin
        o_ack <= i_req.stb;
        o_dat <= mem[idx];
    end

    // ack only follows an accepted strobe
    assert property (@(posedge i_clk)
        o_ack |-> $past(i_req.stb));

endmodule

// File: rtl/soc_bus_top.sv
`timescale 1ns/100ps

module soc_bus_top (
    input  logic                 i_clk,
    input  logic                 reset,
    input  soc_bus_pkg::wb_req_t i_dfetch_req,
    input  soc_bus_pkg::wb_req_t i_ifetch_req,
    input  soc_bus_pkg::wb_req_t i_dbg_req,
    output soc_bus_pkg::wb_rsp_t o_dfetch_rsp,
    output soc_bus_pkg::wb_rsp_t o_ifetch_rsp,
    output soc_bus_pkg::wb_rsp_t o_dbg_rsp,
    output logic                 o_irq
);
    import soc_bus_pkg::*;

    // internal bus, data and instruction fetch merged
    wb_req_t  ibus_req;
    wb_rsp_t  ibus_rsp;

    // main bus into the decoder
    wb_req_t  mbus_req;
    wb_rsp_t  mbus_rsp;

    wb_req_t  ram_req;
    wb_req_t  sys_req;
    logic     ram_ack;
    wb_data_t ram_dat;
    logic     sys_ack;
    wb_data_t sys_dat;
    logic     err_strobe;
    wb_addr_t err_addr;

    // data fetch has priority over instruction fetch
    wb_pri_arbiter ibus_arb (
        .i_clk   (i_clk),
        .reset   (reset),
        .i_a_req (i_dfetch_req),
        .i_b_req (i_ifetch_req),
        .i_rsp   (ibus_rsp),
        .o_req   (ibus_req),
        .o_a_rsp (o_dfetch_rsp),
        .o_b_rsp (o_ifetch_rsp)
    );

    // debug port only gets the idle bus
    wb_pri_arbiter mbus_arb (
        .i_clk   (i_clk),
        .reset   (reset),
        .i_a_req (ibus_req),
        .i_b_req (i_dbg_req),
        .i_rsp   (mbus_rsp),
        .o_req   (mbus_req),
        .o_a_rsp (ibus_rsp),
        .o_b_rsp (o_dbg_rsp)
    );

    periph_decode u_decode (
        .i_clk        (i_clk),
        .reset        (reset),
        .i_req        (mbus_req),
        .i_ram_ack    (ram_ack),
        .i_ram_dat    (ram_dat),
        .i_sys_ack    (sys_ack),
        .i_sys_dat    (sys_dat),
        .o_rsp        (mbus_rsp),
        .o_ram_req    (ram_req),
        .o_sys_req    (sys_req),
        .o_err_strobe (err_strobe),
        .o_err_addr   (err_addr)
    );

    sys_info_regs u_sys (
        .i_clk        (i_clk),
        .reset        (reset),
        .i_req        (sys_req),
        .i_err_strobe (err_strobe),
        .i_err_addr   (err_addr),
        .o_ack        (sys_ack),
        .o_dat        (sys_dat),
        .o_irq        (o_irq)
    );

    wb_ram u_ram (
        .i_clk (i_clk),
        .i_req (ram_req),
        .o_ack (ram_ack),
        .o_dat (ram_dat)
    );

endmodule

// File: dv/soc_bus_model.svh
`ifndef SOC_BUS_MODEL_SVH
`define SOC_BUS_MODEL_SVH

// reference copy of the ram and the system registers
wb_data_t model_ram [0:(1 << RAM_AW)-1];
wb_data_t model_scratch;
logic     model_irq = 1'b0;
wb_addr_t model_err_addr = '0;

// only regions 0 and 1 exist, every region above faults
function automatic logic addr_mapped(input wb_addr_t adr);
    return int'(adr >> 21) < 2;
endfunction

function automatic logic addr_is_power(input wb_addr_t adr);
    return int'(adr >> 21) == 1 && adr[3:0] == REG_POWER;
endfunction

// expected read data, power counter not predicted here
function automatic wb_data_t model_read(input wb_addr_t adr);
    if (int'(adr >> 21) == 0) begin
        return model_ram[adr[RAM_AW-1:0]];
    end
    case (reg_off_t'(adr[3:0]))
        REG_ID:       return SYS_ID;
        REG_SCRATCH:  return model_scratch;
        REG_ERR_ADDR: return {model_err_addr, 2'b00};
        REG_IRQ:      return {31'd0, model_irq};
        default:      return '0;
    endcase
endfunction

function automatic void model_update(input logic we, input wb_addr_t adr,
                                     input wb_data_t dat, input wb_sel_t sel);
    if (!addr_mapped(adr)) begin
        model_err_addr = adr;
    end else if (we && int'(adr >> 21) == 0) begin
        // low ten bits pick the word, the rest alias
        for (int b = 0; b < WB_SW; b++) begin
            if (sel[b]) begin
                model_ram[adr[RAM_AW-1:0]][8*b +: 8] = dat[8*b +: 8];
            end
        end
    end else if (we && adr[3:0] == REG_SCRATCH) begin
        model_scratch = dat;
    end else if (we && adr[3:0] == REG_IRQ) begin
        model_irq = dat[0];
    end
endfunction

// random ram address with random alias bits
function automatic wb_addr_t ram_addr();
    return wb_addr_t'($urandom) & 30'h001f_ffff;
endfunction

function automatic wb_addr_t bad_addr();
    logic [8:0] region;
    region = 9'(2 + $urandom % 510);
    return {region, 21'($urandom)};
endfunction

function automatic wb_addr_t sys_addr(input reg_off_t off);
    return {9'd1, 17'($urandom), off};
endfunction

// one strobe from master m, cyc stays high afterwards
task automatic bus_op(input int m, input logic we, input wb_addr_t adr,
                      input wb_data_t dat, input wb_sel_t sel,
                      output wb_data_t rdat, output logic got_err,
                      output int lat, output int acc_cycle);
    logic accepted;
    logic done;
    accepted  = 1'b0;
    done      = 1'b0;
    lat       = 0;
    rdat      = '0;
    got_err   = 1'b0;
    acc_cycle = 0;
    @(posedge i_clk);
    req[m] <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    // request held unchanged while stalled
    while (!accepted) begin
        @(negedge i_clk);
        if (rsp[m].ack || rsp[m].err) begin
            protocol_error($sformatf("master %0d got a response while waiting", m));
        end
        accepted  = !rsp[m].stall;
        acc_cycle = cycle;
        @(posedge i_clk);
    end
    req[m].stb <= 1'b0;
    while (!done) begin
        @(negedge i_clk);
        lat++;
        if (rsp[m].ack || rsp[m].err) begin
            done    = 1'b1;
            got_err = rsp[m].err;
            rdat    = rsp[m].dat;
            if (rsp[m].ack && rsp[m].err) begin
                protocol_error($sformatf("master %0d saw ack and err together", m));
            end
        end else if (lat > 10) begin
            protocol_error($sformatf("master %0d got no response in 10 cycles", m));
            done = 1'b1;
        end
    end
endtask

task automatic release_bus(input int m);
    @(posedge i_clk);
    req[m] <= '0;
endtask

`endif

// File: dv/soc_bus_tb.sv
`timescale 1ns/100ps

module soc_bus_tb;
    import soc_bus_pkg::*;

    localparam int unsigned SEED = 32'hc5d4_9c6b;
    localparam int N_RAM   = 200;
    localparam int N_ERR   = 40;
    localparam int N_SYS   = 18;
    localparam int N_POWER = 20;
    localparam int N_ARB   = 30;
    // fill, both directed loops, power reads, bursts plus their readback
    localparam int TOTAL_OPS = (1 << RAM_AW) + 2*N_RAM + 2*N_ERR + N_SYS
                               + N_POWER + 1 + 6*N_ARB;
    localparam int TIMEOUT_CYCLES = TOTAL_OPS * 20 + 200;

    logic     i_clk;
    logic     reset;
    wb_req_t  req [3];
    wb_rsp_t  rsp [3];
    logic     irq;
    int       cycle = 0;
    int       n_mismatch = 0;
    int       n_proto = 0;
    string    test_name = "reset";
    int       grant_cyc [3];
    int       done_cyc [3];
    wb_addr_t arb_addrs [$];

    `include "soc_bus_model.svh"

    // master 0 data fetch, 1 instruction fetch, 2 debug
    soc_bus_top DUT (
        .i_clk        (i_clk),
        .reset        (reset),
        .i_dfetch_req (req[0]),
        .i_ifetch_req (req[1]),
        .i_dbg_req    (req[2]),
        .o_dfetch_rsp (rsp[0]),
        .o_ifetch_rsp (rsp[1]),
        .o_dbg_rsp    (rsp[2]),
        .o_irq        (irq)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle <= cycle + 1;
    end

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, expected, actual);
        n_mismatch++;
    endtask

    task automatic protocol_error(input string msg);
        $display("ERROR in %s at cycle %0d: %s", test_name, cycle, msg);
        n_proto++;
    endtask

    // single access checked against the model
    task automatic checked_op(input int m, input logic we, input wb_addr_t adr,
                              input wb_data_t dat, input wb_sel_t sel,
                              output wb_data_t rdat, output int acc_cycle);
        logic     got_err;
        logic     exp_err;
        int       lat;
        wb_data_t exp_dat;
        exp_err = !addr_mapped(adr);
        bus_op(m, we, adr, dat, sel, rdat, got_err, lat, acc_cycle);
        // other masters may have written while this one waited
        exp_dat = model_read(adr);
        if (got_err !== exp_err) begin
            report_mismatch("err", 32'(exp_err), 32'(got_err));
        end
        if (lat != (exp_err ? 1 : 2)) begin
            report_mismatch("latency", exp_err ? 32'd1 : 32'd2, 32'(lat));
        end
        if (!we && !exp_err && !addr_is_power(adr) && rdat !== exp_dat) begin
            report_mismatch("read data", exp_dat, rdat);
        end
        model_update(we, adr, dat, sel);
    endtask

    task automatic arb_burst(input int m);
        wb_data_t rd;
        wb_addr_t a;
        logic     we;
        int       acc;
        for (int i = 0; i < N_ARB; i++) begin
            a  = ram_addr();
            we = 1'($urandom);
            checked_op(m, we, a, $urandom, wb_sel_t'($urandom), rd, acc);
            if (we) begin
                arb_addrs.push_back(a);
            end
            if (i == 0) begin
                grant_cyc[m] = acc;
            end
            done_cyc[m] = acc;
        end
        release_bus(m);
    endtask

    initial begin
        wb_data_t rd;
        wb_data_t prev_pow;
        wb_addr_t a;
        int       acc;
        int       prev_acc;
        void'($urandom(SEED));
        reset  <= 1'b1;
        req[0] <= '0;
        req[1] <= '0;
        req[2] <= '0;
        repeat (5) @(posedge i_clk);
        reset <= 1'b0;

        // every ram word gets a known value first
        test_name = "ram_fill";
        for (int i = 0; i < (1 << RAM_AW); i++) begin
            checked_op(0, 1'b1, wb_addr_t'(i), (32'(i) * 32'h0001_0003) ^ 32'hc3a5_0000,
                       4'hf, rd, acc);
        end

        test_name = "ram_rw";
        for (int i = 0; i < N_RAM; i++) begin
            a = ram_addr();
            checked_op(0, 1'b1, a, $urandom, wb_sel_t'($urandom), rd, acc);
            checked_op(0, 1'b0, a ^ (wb_addr_t'($urandom) & 30'h001f_fc00), '0, 4'hf, rd, acc);
        end
        release_bus(0);

        test_name = "unmapped_err";
        for (int i = 0; i < N_ERR; i++) begin
            checked_op(1, 1'($urandom), bad_addr(), $urandom, 4'hf, rd, acc);
            checked_op(1, 1'b0, sys_addr(REG_ERR_ADDR), '0, 4'hf, rd, acc);
        end
        release_bus(1);

        test_name = "sys_regs";
        checked_op(2, 1'b0, sys_addr(REG_ID), '0, 4'hf, rd, acc);
        checked_op(2, 1'b1, sys_addr(REG_SCRATCH), $urandom, wb_sel_t'($urandom), rd, acc);
        checked_op(2, 1'b0, sys_addr(REG_SCRATCH), '0, 4'hf, rd, acc);
        checked_op(2, 1'b1, sys_addr(REG_IRQ), $urandom | 32'h1, 4'hf, rd, acc);
        if (irq !== 1'b1) begin
            report_mismatch("o_irq", 32'd1, 32'(irq));
        end
        checked_op(2, 1'b0, sys_addr(REG_IRQ), '0, 4'hf, rd, acc);
        checked_op(2, 1'b1, sys_addr(REG_IRQ), $urandom & ~32'h1, 4'hf, rd, acc);
        if (irq !== 1'b0) begin
            report_mismatch("o_irq", 32'd0, 32'(irq));
        end
        checked_op(2, 1'b0, sys_addr(REG_IRQ), '0, 4'hf, rd, acc);
        for (int off = 5; off < 16; off++) begin
            checked_op(2, 1'b0, sys_addr(reg_off_t'(off)), '0, 4'hf, rd, acc);
        end
        release_bus(2);

        // fixed read latency, so counter steps match acceptance gaps
        test_name = "power_counter";
        checked_op(0, 1'b0, sys_addr(REG_POWER), '0, 4'hf, prev_pow, prev_acc);
        for (int i = 0; i < N_POWER; i++) begin
            repeat ($urandom % 6) @(posedge i_clk);
            checked_op(0, 1'b0, sys_addr(REG_POWER), '0, 4'hf, rd, acc);
            if (rd <= prev_pow) begin
                protocol_error("power counter did not increase");
            end
            if (rd - prev_pow !== 32'(acc - prev_acc)) begin
                report_mismatch("power step", 32'(acc - prev_acc), rd - prev_pow);
            end
            prev_pow = rd;
            prev_acc = acc;
        end
        release_bus(0);

        test_name = "arbitration";
        fork
            arb_burst(0);
            arb_burst(1);
            arb_burst(2);
        join
        if (grant_cyc[1] <= done_cyc[0]) begin
            protocol_error("instruction fetch granted before data fetch let go");
        end
        if (grant_cyc[2] <= done_cyc[1]) begin
            protocol_error("debug granted before instruction fetch let go");
        end
        while (arb_addrs.size() > 0) begin
            checked_op(0, 1'b0, arb_addrs.pop_front(), '0, 4'hf, rd, acc);
        end
        release_bus(0);

        $display("summary: %0d mismatches, %0d other errors", n_mismatch, n_proto);
        if (n_mismatch == 0 && n_proto == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge i_clk);
        $display("timeout in %s after %0d cycles, %0d mismatches, %0d other errors",
                 test_name, TIMEOUT_CYCLES, n_mismatch, n_proto);
        $display("Something failed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+dv
common/soc_bus_pkg.sv
rtl/wb_pri_arbiter.sv
periph/periph_decode.sv
periph/sys_info_regs.sv
periph/wb_ram.sv
rtl/soc_bus_top.sv
dv/soc_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the bus fabric testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module soc_bus_tb \
    -f filelist.f -o sim_soc_bus
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_soc_bus > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    exit 1
fi

exit 0
